/* host_domain.f */
+incdir+source
source/host_pkg.sv
source/wait_timer.sv
source/host_bus_fsm.sv
source/l2_banks.sv
source/periph_regs.sv
source/host_domain.sv
dv/tb_host_domain.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the host domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f host_domain.f \
  --top-module tb_host_domain -o sim_host_domain || exit 1

out=$(./obj_dir/sim_host_domain)
echo "$out"
grep -qxF '** PASS **' <<< "$out" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* dv/tb_host_domain.sv */
/*
 * Host domain testbench
 * Table-driven and random host traffic checked against a reference model
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module tb_host_domain
  import host_pkg::*;
;

  localparam logic [31:0] SEED = 32'hf2715c4a;
  localparam int RSP_LIMIT = `PERIPH_WAIT + 8;
  localparam logic [`HOST_NUM_GPIO-1:0] GPIO_IN_VAL = 16'h5a3c;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } stim_t;

  logic clk_i, rst_n_i, req_i, we_i;
  addr_t addr_i;
  data_t wdata_i, rdata_o, exit_o;
  logic rsp_valid_o, err_o, busy_o;
  logic [`HOST_NUM_GPIO-1:0] gpio_in_i, gpio_out_o, gpio_dir_o;

  stim_t tbl [$];

  // Reference model
  data_t l2_model [`L2_WORDS];
  bit written [`L2_WORDS];
  logic [7:0] wr_list [$];
  logic [`HOST_NUM_GPIO-1:0] gpio_out_exp, gpio_dir_exp;
  data_t exit_exp;

  int data_errs, err_errs, gpio_errs, proto_errs;
  int req_count, rsp_pulses;

  host_domain u_dut (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .busy_o      ( busy_o      ),
    .gpio_in_i   ( gpio_in_i   ),
    .gpio_out_o  ( gpio_out_o  ),
    .gpio_dir_o  ( gpio_dir_o  ),
    .exit_o      ( exit_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Every response cycle seen on the bus
  always @(negedge clk_i) begin
    if (rsp_valid_o) begin
      rsp_pulses++;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t got);
    if (got !== exp) begin
      data_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      err_errs++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_gpio(input string name, input logic [`HOST_NUM_GPIO-1:0] exp,
                            input logic [`HOST_NUM_GPIO-1:0] got);
    if (got !== exp) begin
      gpio_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      proto_errs++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic add_entry(input logic we, input addr_t addr, input data_t wdata,
                           input data_t exp_rdata, input logic exp_err);
    stim_t e;
    e = '{we, addr, wdata, exp_rdata, exp_err};
    tbl.push_back(e);
  endtask

  task automatic note_l2_write(input logic [7:0] idx, input data_t data);
    l2_model[idx] = data;
    if (!written[idx]) begin
      written[idx] = 1'b1;
      wr_list.push_back(idx);
    end
  endtask

  // Expected side effects of a write, from the address map
  task automatic update_model(input stim_t e);
    if (e.we) begin
      if (e.addr < addr_t'(`L2_WORDS)) begin
        note_l2_write(e.addr[7:0], e.wdata);
      end else if (e.addr == addr_t'(`PERIPH_BASE)) begin
        gpio_out_exp = e.wdata[`HOST_NUM_GPIO-1:0];
      end else if (e.addr == addr_t'(`PERIPH_BASE + 1)) begin
        gpio_dir_exp = e.wdata[`HOST_NUM_GPIO-1:0];
      end else if (e.addr == addr_t'(`PERIPH_BASE + 3)) begin
        exit_exp = e.wdata;
      end
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the response
  task automatic issue_request(input logic we, input addr_t addr, input data_t wdata,
                               output data_t rdata, output logic err);
    int waited;
    logic seen;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    req_count++;
    @(negedge clk_i);
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    if (busy_o !== 1'b1) begin
      proto_errs++;
      $display("busy_o did not rise after the request to address %h", addr);
    end
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < RSP_LIMIT) begin
      if (rsp_valid_o === 1'b1) begin
        seen = 1'b1;
      end else begin
        @(negedge clk_i);
        waited++;
      end
    end
    rdata = rdata_o;
    err   = err_o;
    if (!seen) begin
      proto_errs++;
      $display("No response arrived for the request to address %h", addr);
    end else begin
      if (busy_o !== 1'b0) begin
        proto_errs++;
        $display("busy_o still high in the response cycle for address %h", addr);
      end
      @(negedge clk_i);
      if (rsp_valid_o !== 1'b0) begin
        proto_errs++;
        $display("Response for address %h lasted more than one cycle", addr);
      end
    end
  endtask

  task automatic fill_table();
    // L2 bank interleave, then readback
    add_entry(1'b1, 16'h0000, 32'h1111_1111, 32'h0, 1'b0);
    add_entry(1'b1, 16'h0001, 32'h2222_2222, 32'h0, 1'b0);
    add_entry(1'b1, 16'h0002, 32'h3333_3333, 32'h0, 1'b0);
    add_entry(1'b1, 16'h0003, 32'h4444_4444, 32'h0, 1'b0);
    add_entry(1'b0, 16'h0000, 32'h0, 32'h1111_1111, 1'b0);
    add_entry(1'b0, 16'h0001, 32'h0, 32'h2222_2222, 1'b0);
    add_entry(1'b0, 16'h0002, 32'h0, 32'h3333_3333, 1'b0);
    add_entry(1'b0, 16'h0003, 32'h0, 32'h4444_4444, 1'b0);
    add_entry(1'b1, 16'h00ff, 32'hdead_beef, 32'h0, 1'b0);
    add_entry(1'b0, 16'h00ff, 32'h0, 32'hdead_beef, 1'b0);
    // Unmapped, 0x0100 would alias word 0 if decoded wrongly
    add_entry(1'b1, 16'h0100, 32'hcafe_f00d, 32'h0, 1'b1);
    add_entry(1'b1, 16'h4000, 32'h0bad_c0de, 32'h0, 1'b1);
    add_entry(1'b0, 16'h4000, 32'h0, 32'h0, 1'b1);
    add_entry(1'b0, 16'h0000, 32'h0, 32'h1111_1111, 1'b0);
    // Peripheral registers
    add_entry(1'b1, 16'h8000, 32'h0000_a5a5, 32'h0, 1'b0);
    add_entry(1'b1, 16'h8001, 32'h0000_3c0f, 32'h0, 1'b0);
    add_entry(1'b1, 16'h8003, 32'h0000_0001, 32'h0, 1'b0);
    add_entry(1'b0, 16'h8000, 32'h0, 32'h0000_a5a5, 1'b0);
    add_entry(1'b0, 16'h8001, 32'h0, 32'h0000_3c0f, 1'b0);
    add_entry(1'b0, 16'h8003, 32'h0, 32'h0000_0001, 1'b0);
    add_entry(1'b0, 16'h8002, 32'h0, {16'h0000, GPIO_IN_VAL}, 1'b0);
    add_entry(1'b1, 16'h8002, 32'hffff_ffff, 32'h0, 1'b1);
    add_entry(1'b0, 16'h8004, 32'h0, 32'h0, 1'b1);
    add_entry(1'b1, 16'h8003, 32'h8000_0000, 32'h0, 1'b0);
    add_entry(1'b0, 16'h8003, 32'h0, 32'h8000_0000, 1'b0);
  endtask

  // Run limit scales with the number of accesses
  initial begin : watchdog
    int limit;
    int cycles;
    @(posedge rst_n_i);
    limit  = (tbl.size() + 128) * (`PERIPH_WAIT + 4) + 50;
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    data_t rdata;
    logic err;
    logic [31:0] rnd;
    logic [7:0] ridx;
    int k;
    int total;
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    gpio_in_i = GPIO_IN_VAL;
    gpio_out_exp = '0;
    gpio_dir_exp = '0;
    exit_exp     = '0;
    fill_table();
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Reset state
    check_gpio("gpio_out_o", '0, gpio_out_o);
    check_gpio("gpio_dir_o", '0, gpio_dir_o);
    check_data("exit_o", '0, exit_o);
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("rsp_valid_o", 1'b0, rsp_valid_o);

    for (int i = 0; i < tbl.size(); i++) begin
      issue_request(tbl[i].we, tbl[i].addr, tbl[i].wdata, rdata, err);
      update_model(tbl[i]);
      check_data("rdata_o", tbl[i].exp_rdata, rdata);
      check_err("err_o", tbl[i].exp_err, err);
      check_gpio("gpio_out_o", gpio_out_exp, gpio_out_o);
      check_gpio("gpio_dir_o", gpio_dir_exp, gpio_dir_o);
      check_data("exit_o", exit_exp, exit_o);
    end

    // Random L2 writes anywhere in the 256 words
    rnd = SEED;
    for (int n = 0; n < 64; n++) begin
      rnd  = lcg_next(rnd);
      ridx = rnd[23:16];
      rnd  = lcg_next(rnd);
      issue_request(1'b1, addr_t'(ridx), rnd, rdata, err);
      note_l2_write(ridx, rnd);
      check_data("rdata_o", '0, rdata);
      check_err("err_o", 1'b0, err);
    end

    // Random reads of words the model knows
    for (int n = 0; n < 64; n++) begin
      rnd  = lcg_next(rnd);
      k    = int'(rnd[31:8]) % wr_list.size();
      ridx = wr_list[k];
      issue_request(1'b0, addr_t'(ridx), '0, rdata, err);
      check_data("rdata_o", l2_model[ridx], rdata);
      check_err("err_o", 1'b0, err);
    end

    @(negedge clk_i);
    if (rsp_pulses != req_count) begin
      proto_errs++;
      $display("Saw %0d response cycles for %0d requests", rsp_pulses, req_count);
    end

    total = data_errs + err_errs + gpio_errs + proto_errs;
    $display("Errors: data %0d, err %0d, gpio %0d, protocol %0d",
             data_errs, err_errs, gpio_errs, proto_errs);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* source/host_domain.sv */
/*
 * Host domain top level
 * Bus FSM, wait timer, L2 banks and peripheral registers
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module host_domain
  import host_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  addr_t                     addr_i,
  input  data_t                     wdata_i,
  output logic                      rsp_valid_o,
  output data_t                     rdata_o,
  output logic                      err_o,
  output logic                      busy_o,
  input  logic [`HOST_NUM_GPIO-1:0] gpio_in_i,
  output logic [`HOST_NUM_GPIO-1:0] gpio_out_o,
  output logic [`HOST_NUM_GPIO-1:0] gpio_dir_o,
  output data_t                     exit_o
);

  // FSM to L2
  logic     l2_req, l2_we;
  l2_idx_t  l2_idx;
  data_t    l2_wdata, l2_rdata;

  // FSM to peripherals
  logic     per_req, per_we, per_err;
  reg_sel_e per_sel;
  data_t    per_wdata, per_rdata;

  // FSM to timer
  logic     tmr_start, tmr_done;

  host_bus_fsm u_bus_fsm (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .busy_o      ( busy_o      ),
    .l2_req_o    ( l2_req      ),
    .l2_we_o     ( l2_we       ),
    .l2_idx_o    ( l2_idx      ),
    .l2_wdata_o  ( l2_wdata    ),
    .l2_rdata_i  ( l2_rdata    ),
    .per_req_o   ( per_req     ),
    .per_we_o    ( per_we      ),
    .per_sel_o   ( per_sel     ),
    .per_wdata_o ( per_wdata   ),
    .per_rdata_i ( per_rdata   ),
    .per_err_i   ( per_err     ),
    .tmr_start_o ( tmr_start   ),
    .tmr_done_i  ( tmr_done    )
  );

  wait_timer u_wait_timer (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .start_i ( tmr_start ),
    .done_o  ( tmr_done  )
  );

  l2_banks u_l2_banks (
    .clk_i   ( clk_i    ),
    .req_i   ( l2_req   ),
    .we_i    ( l2_we    ),
    .idx_i   ( l2_idx   ),
    .wdata_i ( l2_wdata ),
    .rdata_o ( l2_rdata )
  );

  periph_regs u_periph_regs (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( per_req    ),
    .we_i       ( per_we     ),
    .sel_i      ( per_sel    ),
    .wdata_i    ( per_wdata  ),
    .rdata_o    ( per_rdata  ),
    .err_o      ( per_err    ),
    .gpio_in_i  ( gpio_in_i  ),
    .gpio_out_o ( gpio_out_o ),
    .gpio_dir_o ( gpio_dir_o ),
    .exit_o     ( exit_o     )
  );

endmodule

/* source/periph_regs.sv */
/*
 * Peripheral registers
 * GPIO output, direction and input plus the exit register
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module periph_regs
  import host_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  reg_sel_e                  sel_i,
  input  data_t                     wdata_i,
  output data_t                     rdata_o,
  output logic                      err_o,
  input  logic [`HOST_NUM_GPIO-1:0] gpio_in_i,
  output logic [`HOST_NUM_GPIO-1:0] gpio_out_o,
  output logic [`HOST_NUM_GPIO-1:0] gpio_dir_o,
  output data_t                     exit_o
);

  logic [`HOST_NUM_GPIO-1:0] gpio_out_q, gpio_dir_q;
  data_t                     exit_q;
  logic                      wr_en;

  // GPIO input is read-only
  assign err_o = req_i && we_i && (sel_i == REG_GPIO_IN);
  assign wr_en = req_i && we_i && (sel_i != REG_GPIO_IN);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      exit_q     <= '0;
    end else if (wr_en) begin
      case (sel_i)
        REG_GPIO_OUT: gpio_out_q <= wdata_i[`HOST_NUM_GPIO-1:0];
        REG_GPIO_DIR: gpio_dir_q <= wdata_i[`HOST_NUM_GPIO-1:0];
        REG_EXIT:     exit_q     <= wdata_i;
        default:      ;
      endcase
    end
  end

  // Read mux, narrow registers zero-extended
  always_comb begin
    case (sel_i)
      REG_GPIO_OUT: rdata_o = data_t'(gpio_out_q);
      REG_GPIO_DIR: rdata_o = data_t'(gpio_dir_q);
      REG_GPIO_IN:  rdata_o = data_t'(gpio_in_i);
      default:      rdata_o = exit_q;
    endcase
  end

  assign gpio_out_o = gpio_out_q;
  assign gpio_dir_o = gpio_dir_q;
  assign exit_o     = exit_q;

  // Outputs move only after a write strobe from the bus FSM
  a_out_after_write : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$stable({gpio_out_o, gpio_dir_o, exit_o}) |-> $past(req_i && we_i)
  ) else $error("periph_regs: output changed without a write");

endmodule

/* source/l2_banks.sv */
/*
 * L2 memory
 * Four word-interleaved banks with a registered read path
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module l2_banks
  import host_pkg::*;
(
  input  logic    clk_i,
  input  logic    req_i,
  input  logic    we_i,
  input  l2_idx_t idx_i,
  input  data_t   wdata_i,
  output data_t   rdata_o
);

  localparam int unsigned NB     = `L2_NB_BANKS;
  localparam int unsigned BANK_W = $clog2(`L2_NB_BANKS);
  localparam int unsigned ROW_W  = $clog2(`L2_BANK_WORDS);

  logic [NB-1:0]     bank_en;
  logic [ROW_W-1:0]  row;
  logic [BANK_W-1:0] bank_sel_q;
  data_t             bank_rdata_q [NB];

  assign row = idx_i[BANK_W +: ROW_W];

  // One-hot bank enable from the low index bits
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      bank_en[b] = req_i && (idx_i[BANK_W-1:0] == BANK_W'(b));
    end
  end

  for (genvar b = 0; b < NB; b++) begin : g_bank
    data_t mem_q [`L2_BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (bank_en[b]) begin
        if (we_i) begin
          mem_q[row] <= wdata_i;
        end else begin
          bank_rdata_q[b] <= mem_q[row];
        end
      end
    end
  end

  // Remember which bank answers the read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      bank_sel_q <= idx_i[BANK_W-1:0];
    end
  end

  assign rdata_o = bank_rdata_q[bank_sel_q];

endmodule

/* source/host_bus_fsm.sv */
/*
 * Host bus FSM
 * Takes one host request, decodes the region, steers the L2 or the
 * peripheral block and returns a single registered response
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module host_bus_fsm
  import host_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Host side
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  input  data_t    wdata_i,
  output logic     rsp_valid_o,
  output data_t    rdata_o,
  output logic     err_o,
  output logic     busy_o,

  // L2 side
  output logic     l2_req_o,
  output logic     l2_we_o,
  output l2_idx_t  l2_idx_o,
  output data_t    l2_wdata_o,
  input  data_t    l2_rdata_i,

  // Peripheral side
  output logic     per_req_o,
  output logic     per_we_o,
  output reg_sel_e per_sel_o,
  output data_t    per_wdata_o,
  input  data_t    per_rdata_i,
  input  logic     per_err_i,

  // Timer side
  output logic     tmr_start_o,
  input  logic     tmr_done_i
);

  typedef enum logic [2:0] {
    IDLE,
    L2_ACC,
    L2_RSP,
    PER_WAIT,
    ERR_RSP
  } state_e;

  state_e state_q, state_d;

  // Captured request, offset is relative to the hit region
  logic  we_q;
  addr_t off_q;
  data_t wdata_q;

  addr_t l2_off, per_off;
  logic  hit_l2, hit_per;

  logic  tmr_start_q;
  logic  rsp_now, rsp_err;
  data_t rsp_data;
  logic  rsp_valid_q, err_q;
  data_t rdata_q;

  // Region decode only
  assign l2_off  = addr_i - addr_t'(`L2_BASE);
  assign per_off = addr_i - addr_t'(`PERIPH_BASE);
  assign hit_l2  = (l2_off < addr_t'(`L2_WORDS));
  assign hit_per = (per_off < addr_t'(`PERIPH_NB_REGS));

  always_comb begin
    state_d  = state_q;
    rsp_now  = 1'b0;
    rsp_err  = 1'b0;
    rsp_data = '0;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (hit_l2) begin
            state_d = L2_ACC;
          end else if (hit_per) begin
            state_d = PER_WAIT;
          end else begin
            state_d = ERR_RSP;
          end
        end
      end
      L2_ACC: state_d = L2_RSP;
      L2_RSP: begin
        rsp_now  = 1'b1;
        rsp_data = we_q ? '0 : l2_rdata_i;
        state_d  = IDLE;
      end
      PER_WAIT: begin
        // Peripheral strobe and its reply share the done cycle
        if (tmr_done_i) begin
          rsp_now  = 1'b1;
          rsp_err  = per_err_i;
          rsp_data = we_q ? '0 : per_rdata_i;
          state_d  = IDLE;
        end
      end
      ERR_RSP: begin
        rsp_now = 1'b1;
        rsp_err = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      tmr_start_q <= 1'b0;
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      tmr_start_q <= (state_q == IDLE) && req_i && !hit_l2 && hit_per;
      rsp_valid_q <= rsp_now;
      err_q       <= rsp_err;
    end
  end

  // Request fields and read data
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && req_i) begin
      we_q    <= we_i;
      wdata_q <= wdata_i;
      off_q   <= hit_l2 ? l2_off : per_off;
    end
    if (rsp_now) begin
      rdata_q <= rsp_data;
    end
  end

  assign busy_o      = (state_q != IDLE);
  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;

  assign l2_req_o    = (state_q == L2_ACC);
  assign l2_we_o     = we_q;
  assign l2_idx_o    = l2_idx_t'(off_q);
  assign l2_wdata_o  = wdata_q;

  assign per_req_o   = (state_q == PER_WAIT) && tmr_done_i;
  assign per_we_o    = we_q;
  assign per_sel_o   = reg_sel_e'(off_q[1:0]);
  assign per_wdata_o = wdata_q;

  assign tmr_start_o = tmr_start_q;

  // Host keeps to one request in flight
  a_req_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> !busy_o
  ) else $error("host_bus_fsm: request while busy");

  // Exactly one response closes every busy window
  a_one_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o == $fell(busy_o)
  ) else $error("host_bus_fsm: response does not match busy window");

endmodule

/* source/wait_timer.sv */
/*
 * Wait-state timer
 * Counts down PERIPH_WAIT cycles after a start pulse, then pulses done
 */

`timescale 1ns/1ps

`include "host_settings.svh"

module wait_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  localparam int unsigned CNT_W = $clog2(`PERIPH_WAIT + 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      // Last decrement raises done for one cycle
      done_o <= (cnt_q == CNT_W'(1));
      if (start_i) begin
        cnt_q <= CNT_W'(`PERIPH_WAIT);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // Bus FSM must not restart a wait that is still running
  a_no_restart : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> (cnt_q == '0)
  ) else $error("wait_timer: start while counting");

endmodule

/* source/host_pkg.sv */
/*
 * Host domain package
 * Address, data, L2 index and register-select types
 */

`include "host_settings.svh"

package host_pkg;

  typedef logic [`HOST_ADDR_W-1:0] addr_t;
  typedef logic [`HOST_DATA_W-1:0] data_t;

  // Low bits pick the bank, high bits the row
  localparam int unsigned L2_IDX_W = $clog2(`L2_WORDS);
  typedef logic [L2_IDX_W-1:0] l2_idx_t;

  // Peripheral register map, word offsets from PERIPH_BASE
  typedef enum logic [1:0] {
    REG_GPIO_OUT = 2'd0,
    REG_GPIO_DIR = 2'd1,
    REG_GPIO_IN  = 2'd2,
    REG_EXIT     = 2'd3
  } reg_sel_e;

endpackage

/* source/host_settings.svh */
/*
 * Host domain settings
 * Widths, L2 bank geometry, region bases and peripheral wait states
 */

`ifndef HOST_SETTINGS_SVH
`define HOST_SETTINGS_SVH

// Bus widths
`define HOST_ADDR_W     16
`define HOST_DATA_W     32
`define HOST_NUM_GPIO   16

// L2 geometry, word interleaved
`define L2_NB_BANKS     4
`define L2_BANK_WORDS   64
`define L2_BASE         16'h0000
`define L2_WORDS        (`L2_NB_BANKS * `L2_BANK_WORDS)

// Peripheral region
`define PERIPH_BASE     16'h8000
`define PERIPH_NB_REGS  4
`define PERIPH_WAIT     3

`endif
